//--- all.f
verilog/gat_pkg.sv
verilog/wh_bram.sv
verilog/wh_port_arbiter.sv
verilog/wh_row_writer.sv
verilog/dmvm_core.sv
verilog/gat_coef_top.sv
tests/clk_gen.sv
tests/tb_gat_coef.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_gat_coef -f all.f
./obj_dir/Vtb_gat_coef

//--- tests/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 40 ns period
  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // reset low over the first two rising edges, released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

//--- tests/gat_coef_vectors.txt
# name op fields, all hex: W addr wh0 wh1 wh2 wh3 num_nodes src_flag | S base a0..a7
# E c0..c7 | R base count (random rows written during the run) | C (run the random rows)
small_r0 W 0 05 04 03 02 3 1
small_r1 W 1 03 06 02 04 0 0
small_r2 W 2 0a 01 05 03 0 0
small_run S 0 01 02 03 01 02 01 01 02
small_coef E 30 2e 38 00 00 00 00 00
sat_r0 W 3 c8 ff 20 ff 3 1
sat_r1 W 4 03 01 80 0f 0 0
sat_r2 W 5 00 00 01 01 0 0
sat_run S 3 c8 ff 10 80 40 fa 02 11
arb_writes R a 4
sat_coef E ff ff ba 00 00 00 00 00
flag_r0 W 6 01 02 03 04 2 1
flag_r1 W 7 02 02 02 02 0 0
flag_set_run S 6 02 03 04 05 01 01 01 01
flag_set_coef E 50 30 00 00 00 00 00 00
flag_clr_r0 W 6 01 02 03 04 2 0
flag_clr_run S 6 02 03 04 05 01 01 01 01
flag_clr_coef E 14 12 00 00 00 00 00 00
rand_rows C

//--- tests/tb_gat_coef.sv
`timescale 1ns/1ps

module tb_gat_coef import gat_pkg::*; ();

  logic              clk;
  logic              rst_n;
  logic              wr;
  logic [ADDR_W-1:0] wr_addr;
  wh_row_t           wr_row;
  logic              wr_busy;
  logic              start;
  logic [ADDR_W-1:0] base_addr;
  a_vec_t            a_vec;
  logic              busy;
  logic              done;
  coef_vec_t         coef;

  // run bookkeeping
  string             lines [$];
  int                cycles = 0;
  int                limit = 0;
  int                runs = 0;
  int                done_cnt = 0;
  coef_vec_t         last_coef;
  integer            seed = 32'h2d93;

  // rows written at random during a run
  logic [DATA_W-1:0] rnd_w0 [MAX_NODES];
  logic [ADDR_W-1:0] rnd_base;
  int                rnd_cnt = 0;

  clk_gen i_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  gat_coef_top i_gat_coef_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_i        (wr),
    .wr_addr_i   (wr_addr),
    .wr_row_i    (wr_row),
    .wr_busy_o   (wr_busy),
    .start_i     (start),
    .base_addr_i (base_addr),
    .a_i         (a_vec),
    .busy_o      (busy),
    .done_o      (done),
    .coef_o      (coef)
  );

  task automatic stop_with_error(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_coef(input string name, input coef_vec_t exp_v, input coef_vec_t act_v);
    if (act_v !== exp_v) begin
      $display("MISMATCH %s expected %h actual %h", name, exp_v, act_v);
      $display("Test FAILED");
      $fatal(1, "coefficient mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("MISMATCH %s expected %b actual %b", name, exp_v, act_v);
      $display("Test FAILED");
      $fatal(1, "level mismatch");
    end
  endtask

  // done pulses seen so far
  always @(posedge clk) begin
    if (done === 1'b1) begin
      done_cnt <= done_cnt + 1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit != 0 && cycles > limit) begin
      stop_with_error($sformatf("timeout, run exceeded %0d cycles", limit));
    end
  end

  task automatic write_row(input logic [ADDR_W-1:0] addr, input wh_row_t row);
    while (wr_busy) @(negedge clk);
    wr      = 1'b1;
    wr_addr = addr;
    wr_row  = row;
    @(negedge clk);
    wr = 1'b0;
    // buffer holds the write until the port is granted
    check_flag($sformatf("write %0h wr_busy", addr), 1'b1, wr_busy);
  endtask

  task automatic start_run(input string name, input logic [ADDR_W-1:0] base, input a_vec_t a);
    while (busy) @(negedge clk);
    start     = 1'b1;
    base_addr = base;
    a_vec     = a;
    runs++;
    @(negedge clk);
    check_flag({name, " busy"}, 1'b1, busy);
    // a second strobe with other operands lands while busy
    base_addr = base + ADDR_W'(5);
    a_vec     = ~a;
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic expect_coef(input string name, input coef_vec_t exp_v);
    // old vector holds until this run's done
    while (done_cnt < runs && !done) begin
      check_coef({name, " hold"}, last_coef, coef);
      @(negedge clk);
    end
    check_coef(name, exp_v, coef);
    @(negedge clk);
    @(negedge clk);
    check_flag({name, " done low"}, 1'b0, done);
    check_flag({name, " busy low"}, 1'b0, busy);
    if (done_cnt != runs) begin
      stop_with_error({name, ": done did not pulse exactly once per run"});
    end
    last_coef = exp_v;
  endtask

  task automatic write_random(input string name, input logic [ADDR_W-1:0] base, input int count);
    wh_row_t row;
    check_flag({name, " run in progress"}, 1'b1, busy);
    for (int k = 0; k < count; k++) begin
      row.wh        = 32'($random(seed));
      row.num_nodes = (k == 0) ? NODE_W'(count) : '0;
      row.src_flag  = (k == 0);
      rnd_w0[k]     = row.wh[0];
      write_row(base + ADDR_W'(k), row);
    end
    rnd_base = base;
    rnd_cnt  = count;
  endtask

  // only element 0 of each half is one so each score is the row's first byte
  task automatic run_random(input string name);
    a_vec_t    a;
    coef_vec_t exp_v;
    int        sum;
    a         = '0;
    a[0]      = 8'd1;
    a[HALF_A] = 8'd1;
    exp_v     = '0;
    for (int i = 0; i < rnd_cnt; i++) begin
      sum      = int'(rnd_w0[0]) + int'(rnd_w0[i]);
      exp_v[i] = (sum > MAX_VAL) ? 8'(MAX_VAL) : 8'(sum);
    end
    start_run(name, rnd_base, a);
    expect_coef(name, exp_v);
  endtask

  initial begin
    string     line;
    string     name;
    string     op;
    int        fd;
    int        n;
    int        v [9];
    wh_row_t   row;
    a_vec_t    a;
    coef_vec_t exp_v;
    wr        = 1'b0;
    wr_addr   = '0;
    wr_row    = '0;
    start     = 1'b0;
    base_addr = '0;
    a_vec     = '0;
    last_coef = '0;
    fd = $fopen("tests/gat_coef_vectors.txt", "r");
    if (fd == 0) begin
      stop_with_error("cannot open tests/gat_coef_vectors.txt");
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 1 && line.getc(0) != "#") begin
        lines.push_back(line);
      end
    end
    $fclose(fd);
    limit = 100 * (lines.size() + 1);

    wait (rst_n === 1'b1);
    @(negedge clk);
    check_flag("reset busy", 1'b0, busy);
    check_flag("reset done", 1'b0, done);
    check_flag("reset wr_busy", 1'b0, wr_busy);
    check_coef("reset coef", '0, coef);

    foreach (lines[i]) begin
      n = $sscanf(lines[i], "%s %s %h %h %h %h %h %h %h %h %h", name, op,
                  v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8]);
      if (op == "W") begin
        row.wh        = {8'(v[1]), 8'(v[2]), 8'(v[3]), 8'(v[4])};
        row.num_nodes = NODE_W'(v[5]);
        row.src_flag  = v[6][0];
        write_row(ADDR_W'(v[0]), row);
      end else if (op == "S") begin
        for (int j = 0; j < A_LEN; j++) begin
          a[j] = 8'(v[j+1]);
        end
        start_run(name, ADDR_W'(v[0]), a);
      end else if (op == "E") begin
        for (int j = 0; j < MAX_NODES; j++) begin
          exp_v[j] = 8'(v[j]);
        end
        expect_coef(name, exp_v);
      end else if (op == "R") begin
        write_random(name, ADDR_W'(v[0]), v[1]);
      end else if (op == "C") begin
        run_random(name);
      end else begin
        stop_with_error({"unknown opcode in vector line ", name});
      end
    end

    $display("Test OK");
    $finish;
  end

endmodule

//--- verilog/dmvm_core.sv
`timescale 1ns/1ps

module dmvm_core import gat_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start_i,
  input  logic [ADDR_W-1:0] base_addr_i,
  input  a_vec_t            a_i,
  input  logic              gnt_i,
  input  logic              rd_valid_i,
  input  wh_row_t           rdata_i,
  output mem_req_t          req_o,
  output logic              busy_o,
  output logic              done_o,
  output coef_vec_t         coef_o
);

  // control state
  core_state_e       state_q;
  logic [NODE_W-1:0] row_cnt_q;
  logic [NODE_W-1:0] n_nodes_q;
  logic [1:0]        red_cnt_q;
  coef_vec_t         coef_q;
  logic              last_row;
  logic              last_red;

  // run operands and pipeline data
  a_vec_t            a_q;
  logic [ADDR_W-1:0] base_q;
  wh_row_t           row_q;
  logic [DATA_W-1:0] tree_q  [HALF_A];
  logic [DATA_W-1:0] score_q [MAX_NODES];

  // combinational stage results
  logic [2*DATA_W-1:0] mul_c  [HALF_A];
  logic [DATA_W-1:0]   prod_c [HALF_A];
  logic [DATA_W:0]     sum_c  [HALF_A/2];
  logic [DATA_W-1:0]   pair_c [HALF_A/2];
  logic [DATA_W:0]     rsum_c [MAX_NODES];
  coef_vec_t           coef_c;

  // source row uses the first half of a
  always_comb begin
    for (int i = 0; i < HALF_A; i++) begin
      mul_c[i] = (row_q.src_flag ? a_q[i] : a_q[HALF_A + i]) * row_q.wh[i];
      // overflow keeps the upper byte
      if (mul_c[i] <= MAX_VAL) begin
        prod_c[i] = mul_c[i][DATA_W-1:0];
      end else begin
        prod_c[i] = mul_c[i][2*DATA_W-1:DATA_W];
      end
    end
  end

  // one level of the adder tree, overflow halves the sum
  always_comb begin
    for (int x = 0; x < HALF_A / 2; x++) begin
      sum_c[x] = tree_q[2*x] + tree_q[2*x+1];
      if (sum_c[x] <= MAX_VAL) begin
        pair_c[x] = sum_c[x][DATA_W-1:0];
      end else begin
        pair_c[x] = sum_c[x][DATA_W:1];
      end
    end
  end

  // ReLU stage, source score plus neighbour score, clamped
  always_comb begin
    for (int i = 0; i < MAX_NODES; i++) begin
      rsum_c[i] = score_q[0] + score_q[i];
      if (i >= n_nodes_q) begin
        coef_c[i] = '0;
      end else if (rsum_c[i] > MAX_VAL) begin
        coef_c[i] = DATA_W'(MAX_VAL);
      end else begin
        coef_c[i] = rsum_c[i][DATA_W-1:0];
      end
    end
  end

  assign last_red = (red_cnt_q == 2'($clog2(HALF_A) - 1));
  assign last_row = (({1'b0, row_cnt_q} + 1'b1) >= {1'b0, n_nodes_q}) ||
                    (row_cnt_q == NODE_W'(MAX_NODES - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q   <= IDLE;
      row_cnt_q <= '0;
      n_nodes_q <= '0;
      red_cnt_q <= '0;
      coef_q    <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (start_i) begin
            row_cnt_q <= '0;
            state_q   <= FETCH;
          end
        end
        // stalls here while the writer holds the port
        FETCH: begin
          if (gnt_i) begin
            state_q <= WAIT_DATA;
          end
        end
        WAIT_DATA: begin
          if (rd_valid_i) begin
            // node count comes from the first row
            if (row_cnt_q == '0) begin
              n_nodes_q <= rdata_i.num_nodes;
            end
            state_q <= PRODUCT;
          end
        end
        PRODUCT: begin
          red_cnt_q <= '0;
          state_q   <= REDUCE;
        end
        REDUCE: begin
          red_cnt_q <= red_cnt_q + 1'b1;
          if (last_red) begin
            state_q <= STORE;
          end
        end
        STORE: begin
          if (last_row) begin
            state_q <= RELU;
          end else begin
            row_cnt_q <= row_cnt_q + 1'b1;
            state_q   <= FETCH;
          end
        end
        RELU: begin
          coef_q  <= coef_c;
          state_q <= DONE;
        end
        DONE: begin
          state_q <= IDLE;
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == IDLE && start_i) begin
      a_q    <= a_i;
      base_q <= base_addr_i;
    end
    if (state_q == WAIT_DATA && rd_valid_i) begin
      row_q <= rdata_i;
    end
    if (state_q == PRODUCT) begin
      tree_q <= prod_c;
    end
    if (state_q == REDUCE) begin
      for (int x = 0; x < HALF_A / 2; x++) begin
        tree_q[x] <= pair_c[x];
      end
    end
    if (state_q == STORE) begin
      score_q[row_cnt_q[$clog2(MAX_NODES)-1:0]] <= tree_q[0];
    end
  end

  // read request for row base + k
  always_comb begin
    req_o      = '0;
    req_o.req  = (state_q == FETCH);
    req_o.addr = base_q + ADDR_W'(row_cnt_q);
  end

  assign busy_o = (state_q != IDLE);
  assign done_o = (state_q == DONE);
  assign coef_o = coef_q;

endmodule

//--- verilog/gat_coef_top.sv
`timescale 1ns/1ps

module gat_coef_top import gat_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              wr_i,
  input  logic [ADDR_W-1:0] wr_addr_i,
  input  wh_row_t           wr_row_i,
  output logic              wr_busy_o,
  input  logic              start_i,
  input  logic [ADDR_W-1:0] base_addr_i,
  input  a_vec_t            a_i,
  output logic              busy_o,
  output logic              done_o,
  output coef_vec_t         coef_o
);

  // memory port traffic
  mem_req_t wr_req;
  mem_req_t rd_req;
  mem_req_t mem_req;
  logic     wr_gnt;
  logic     rd_gnt;
  logic     rd_valid;
  wh_row_t  rdata;

  wh_row_writer i_wh_row_writer (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_i      (wr_i),
    .wr_addr_i (wr_addr_i),
    .wr_row_i  (wr_row_i),
    .gnt_i     (wr_gnt),
    .req_o     (wr_req),
    .wr_busy_o (wr_busy_o)
  );

  dmvm_core i_dmvm_core (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .base_addr_i (base_addr_i),
    .a_i         (a_i),
    .gnt_i       (rd_gnt),
    .rd_valid_i  (rd_valid),
    .rdata_i     (rdata),
    .req_o       (rd_req),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .coef_o      (coef_o)
  );

  // writer has priority over the core
  wh_port_arbiter i_wh_port_arbiter (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_req_i   (wr_req),
    .rd_req_i   (rd_req),
    .wr_gnt_o   (wr_gnt),
    .rd_gnt_o   (rd_gnt),
    .rd_valid_o (rd_valid),
    .mem_req_o  (mem_req)
  );

  wh_bram i_wh_bram (
    .clk     (clk),
    .req_i   (mem_req),
    .rdata_o (rdata)
  );

endmodule

//--- verilog/gat_pkg.sv
package gat_pkg;

  // value and vector sizes
  localparam int DATA_W    = 8;
  localparam int A_LEN     = 8;
  localparam int HALF_A    = A_LEN / 2;

  // sub-graph and memory sizes
  localparam int MAX_NODES = 8;
  localparam int NODE_W    = 4;
  localparam int ROWS      = 16;
  localparam int ADDR_W    = 4;

  // byte ceiling for products, sums and ReLU
  localparam int MAX_VAL   = 255;

  // one WH row, element 0 sits in the top byte
  typedef struct packed {
    logic [0:HALF_A-1][DATA_W-1:0] wh;
    logic [NODE_W-1:0]             num_nodes;
    logic                          src_flag;
  } wh_row_t;

  // request into the shared memory port
  typedef struct packed {
    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    wh_row_t           wdata;
  } mem_req_t;

  // attention vector, first half used on the source row
  typedef logic [0:A_LEN-1][DATA_W-1:0] a_vec_t;

  // one coefficient per node of the sub-graph
  typedef logic [0:MAX_NODES-1][DATA_W-1:0] coef_vec_t;

  // dmvm_core sequencer
  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    WAIT_DATA,
    PRODUCT,
    REDUCE,
    STORE,
    RELU,
    DONE
  } core_state_e;

endpackage

//--- verilog/wh_bram.sv
`timescale 1ns/1ps

module wh_bram import gat_pkg::*; (
  input  logic     clk,
  input  mem_req_t req_i,
  output wh_row_t  rdata_o
);

  // row storage, behaves like a block RAM
  wh_row_t mem_q [ROWS];

  // single port, write or registered read
  always_ff @(posedge clk) begin
    if (req_i.req) begin
      if (req_i.we) begin
        mem_q[req_i.addr] <= req_i.wdata;
      end else begin
        rdata_o <= mem_q[req_i.addr];
      end
    end
  end

endmodule

//--- verilog/wh_port_arbiter.sv
`timescale 1ns/1ps

module wh_port_arbiter import gat_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  mem_req_t wr_req_i,
  input  mem_req_t rd_req_i,
  output logic     wr_gnt_o,
  output logic     rd_gnt_o,
  output logic     rd_valid_o,
  output mem_req_t mem_req_o
);

  // set when the core owned a read grant last cycle
  logic rd_valid_q;

  // writer always wins
  assign wr_gnt_o = wr_req_i.req;
  assign rd_gnt_o = rd_req_i.req && !wr_req_i.req;

  // winner drives the memory port, idle port sees no request
  always_comb begin
    if (wr_gnt_o) begin
      mem_req_o = wr_req_i;
    end else if (rd_gnt_o) begin
      mem_req_o = rd_req_i;
    end else begin
      mem_req_o = '0;
    end
  end

  // read data lands one cycle after the grant
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= rd_gnt_o && !rd_req_i.we;
    end
  end

  assign rd_valid_o = rd_valid_q;

endmodule

//--- verilog/wh_row_writer.sv
`timescale 1ns/1ps

module wh_row_writer import gat_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              wr_i,
  input  logic [ADDR_W-1:0] wr_addr_i,
  input  wh_row_t           wr_row_i,
  input  logic              gnt_i,
  output mem_req_t          req_o,
  output logic              wr_busy_o
);

  // buffer state
  logic full_q;

  // buffered write
  logic [ADDR_W-1:0] addr_q;
  wh_row_t           row_q;

  // strobe taken only while empty, cleared on grant
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      full_q <= 1'b0;
    end else if (full_q && gnt_i) begin
      full_q <= 1'b0;
    end else if (!full_q && wr_i) begin
      full_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!full_q && wr_i) begin
      addr_q <= wr_addr_i;
      row_q  <= wr_row_i;
    end
  end

  // hold the write request until granted
  always_comb begin
    req_o       = '0;
    req_o.req   = full_q;
    req_o.we    = full_q;
    req_o.addr  = addr_q;
    req_o.wdata = row_q;
  end

  assign wr_busy_o = full_q;

endmodule
